//--- common/lsu_pkg.sv
package lsu_pkg;

    // MIPS32 primary opcodes, instr[31:26]
    localparam logic [5:0] op_lb  = 6'b100000;
    localparam logic [5:0] op_lh  = 6'b100001;
    localparam logic [5:0] op_lwl = 6'b100010;
    localparam logic [5:0] op_lw  = 6'b100011;
    localparam logic [5:0] op_lbu = 6'b100100;
    localparam logic [5:0] op_lhu = 6'b100101;
    localparam logic [5:0] op_lwr = 6'b100110;
    localparam logic [5:0] op_sb  = 6'b101000;
    localparam logic [5:0] op_sh  = 6'b101001;
    localparam logic [5:0] op_swl = 6'b101010;
    localparam logic [5:0] op_sw  = 6'b101011;
    localparam logic [5:0] op_swr = 6'b101110;
    localparam logic [5:0] op_ll  = 6'b110000;
    localparam logic [5:0] op_sc  = 6'b111000;

    typedef enum logic [3:0] {
        mem_none, mem_lb, mem_lh, mem_lwl, mem_lw, mem_lbu, mem_lhu, mem_lwr,
        mem_sb, mem_sh, mem_swl, mem_sw, mem_swr, mem_ll, mem_sc
    } mem_op_t;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] addr;
        logic [31:0] wdata;     // store source, old rt for lwl/lwr
        logic [4:0]  dest;
        logic        valid;
    } slot_req_t;

    typedef struct packed {
        mem_op_t     op;
        logic [31:0] addr;
        logic [31:0] wdata;     // already lane aligned
        logic [3:0]  strb;
        logic [31:0] rt_value;
        logic [4:0]  dest;
        logic        sc_fail;
        logic        sel;
    } lsu_req_t;

    typedef struct packed {
        mem_op_t     op;
        logic [1:0]  offset;
        logic [31:0] rt_value;
        logic [4:0]  dest;
        logic        sel;       // issue slot, returned with the result
    } load_ctx_t;

    typedef struct packed {
        logic [4:0]  dest;
        logic [31:0] data;
        logic        sel;
    } lsu_rsp_t;

    typedef struct packed {
        logic        sel;
        logic        is_store;
        logic [31:0] badvaddr;
    } lsu_exc_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [2:0]  prot;
    } axi_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } axi_w_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [2:0]  prot;
    } axi_ar_t;

    typedef struct packed {
        logic [1:0] resp;
    } axi_b_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
    } axi_r_t;

endpackage

//--- lsu/access_ctrl.sv
`timescale 1ns/1ps

module access_ctrl (
    input  logic               clk,
    input  logic               arst_n,
    input  lsu_pkg::slot_req_t slot0,
    input  lsu_pkg::slot_req_t slot1,
    input  logic               mem_sel,
    input  logic               req_valid,
    input  logic               fifo_full,
    output logic               req_ready,
    output logic               push,
    output lsu_pkg::lsu_req_t  push_item,
    output lsu_pkg::lsu_exc_t  exc,
    output logic               exc_valid
);
    import lsu_pkg::*;

    slot_req_t   s;
    mem_op_t     op;
    logic [1:0]  offset;
    logic        misaligned;
    logic        is_store;
    logic        mem_acc;
    logic        ready_en;
    logic        link;
    logic [3:0]  st_strb;
    logic [31:0] st_data;

    assign s       = mem_sel ? slot0 : slot1;   // 1 picks slot0
    assign offset  = s.addr[1:0];
    // no new request while an exception is being reported
    assign req_ready = ready_en & ~fifo_full & ~exc_valid;
    assign mem_acc   = req_valid & req_ready & (op != mem_none);
    assign push      = mem_acc & ~misaligned;

    always_comb begin
        op = mem_none;
        if (s.valid) begin
            case (s.instr[31:26])
                op_lb:   op = mem_lb;
                op_lh:   op = mem_lh;
                op_lwl:  op = mem_lwl;
                op_lw:   op = mem_lw;
                op_lbu:  op = mem_lbu;
                op_lhu:  op = mem_lhu;
                op_lwr:  op = mem_lwr;
                op_sb:   op = mem_sb;
                op_sh:   op = mem_sh;
                op_swl:  op = mem_swl;
                op_sw:   op = mem_sw;
                op_swr:  op = mem_swr;
                op_ll:   op = mem_ll;
                op_sc:   op = mem_sc;
                default: op = mem_none;
            endcase
        end
    end

    always_comb begin
        case (op)
            mem_lw, mem_ll, mem_sw, mem_sc: misaligned = (offset != 2'b00);
            mem_lh, mem_lhu, mem_sh:        misaligned = offset[0];
            default:                        misaligned = 1'b0;
        endcase
        is_store = op inside {mem_sb, mem_sh, mem_swl, mem_sw, mem_swr, mem_sc};
    end

    store_format u_store_format (
        .op     (op),
        .offset (offset),
        .wdata  (s.wdata),
        .strb   (st_strb),
        .data   (st_data)
    );

    always_comb begin
        push_item.op       = op;
        push_item.addr     = s.addr;
        push_item.wdata    = st_data;
        push_item.strb     = st_strb;
        push_item.rt_value = s.wdata;
        push_item.dest     = s.dest;
        push_item.sc_fail  = (op == mem_sc) & ~link;
        push_item.sel      = mem_sel;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ready_en  <= 1'b0;
            link      <= 1'b0;
            exc_valid <= 1'b0;
        end else begin
            ready_en  <= 1'b1;
            exc_valid <= mem_acc & misaligned;
            if (mem_acc && op == mem_sc)
                link <= 1'b0;                   // any sc consumes the link
            else if (mem_acc && op == mem_ll && !misaligned)
                link <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_acc && misaligned) begin
            exc.sel      <= mem_sel;
            exc.is_store <= is_store;
            exc.badvaddr <= s.addr;
        end
    end

endmodule

//--- lsu/axi_lite_master.sv
`timescale 1ns/1ps

module axi_lite_master #(
    parameter int RD_DEPTH = 4
) (
    input  logic              clk,
    input  logic              arst_n,
    input  lsu_pkg::lsu_req_t head,
    input  logic              empty,
    input  logic              rsp_ready,
    output logic              pop,
    output lsu_pkg::lsu_rsp_t rsp,
    output logic              rsp_valid,
    output lsu_pkg::axi_aw_t  aw,
    output logic              aw_valid,
    input  logic              aw_ready,
    output lsu_pkg::axi_w_t   w,
    output logic              w_valid,
    input  logic              w_ready,
    output lsu_pkg::axi_ar_t  ar,
    output logic              ar_valid,
    input  logic              ar_ready,
    input  logic              b_valid,
    input  lsu_pkg::axi_b_t   b,
    output logic              b_ready,
    input  logic              r_valid,
    input  lsu_pkg::axi_r_t   r,
    output logic              r_ready
);
    import lsu_pkg::*;

    typedef enum logic [1:0] {st_idle, st_store_wait, st_sc_rsp} state_t;

    state_t      state;
    logic        is_load;
    logic        issue_ld;
    logic        issue_st;
    logic        issue_scf;
    logic        ctx_pop;
    logic        ctx_empty;
    logic        ctx_full;
    load_ctx_t   ctx_in;
    load_ctx_t   ctx_head;
    logic [31:0] ld_data;
    logic        sc_pend;
    logic [31:0] sc_data;
    logic [4:0]  sc_dest;
    logic        sc_sel;

    always_comb begin
        is_load = head.op inside {mem_lb, mem_lh, mem_lwl, mem_lw,
                                  mem_lbu, mem_lhu, mem_lwr, mem_ll};
        // reads stream while no write is open
        issue_ld  = (state == st_idle) & ~empty & is_load & ~ctx_full
                  & (~ar_valid | ar_ready);
        // writes and failed sc wait for all earlier reads to return
        issue_st  = (state == st_idle) & ~empty & ~is_load & ~head.sc_fail & ctx_empty;
        issue_scf = (state == st_idle) & ~empty & head.sc_fail & ctx_empty;
        pop       = issue_ld | issue_st | issue_scf;

        ctx_in.op       = head.op;
        ctx_in.offset   = head.addr[1:0];
        ctx_in.rt_value = head.rt_value;
        ctx_in.dest     = head.dest;
        ctx_in.sel      = head.sel;
    end

    sync_fifo #(
        .item_t (load_ctx_t),
        .DEPTH  (RD_DEPTH)
    ) u_ctx_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (issue_ld),
        .push_item (ctx_in),
        .pop       (ctx_pop),
        .head      (ctx_head),
        .empty     (ctx_empty),
        .full      (ctx_full)
    );

    load_align u_load_align (
        .ctx   (ctx_head),
        .rdata (r.data),
        .data  (ld_data)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= st_idle;
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
            ar_valid <= 1'b0;
            sc_pend  <= 1'b0;
        end else begin
            if (issue_ld)
                ar_valid <= 1'b1;
            else if (ar_ready)
                ar_valid <= 1'b0;
            if (aw_ready)
                aw_valid <= 1'b0;
            if (w_ready)
                w_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (issue_st) begin
                        aw_valid <= 1'b1;           // aw and w go out together
                        w_valid  <= 1'b1;
                        sc_pend  <= (head.op == mem_sc);
                        state    <= st_store_wait;
                    end else if (issue_scf) begin
                        state <= st_sc_rsp;
                    end
                end
                st_store_wait: begin
                    if (b_valid && b_ready)
                        state <= sc_pend ? st_sc_rsp : st_idle;
                end
                st_sc_rsp: begin
                    if (rsp_ready)
                        state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue_ld) begin
            ar.addr <= {head.addr[31:2], 2'b00};
            ar.prot <= 3'b000;
        end
        if (issue_st) begin
            aw.addr <= {head.addr[31:2], 2'b00};
            aw.prot <= 3'b000;
            w.data  <= head.wdata;
            w.strb  <= head.strb;
        end
        if (issue_st || issue_scf) begin
            sc_dest <= head.dest;
            sc_sel  <= head.sel;
        end
        if (issue_scf)
            sc_data <= 32'd0;
        else if (b_valid && b_ready)
            sc_data <= {31'b0, b.resp == 2'b00};    // sc succeeds on okay only
    end

    assign b_ready = (state == st_store_wait);
    assign r_ready = rsp_ready & ~ctx_empty & (state != st_sc_rsp);
    assign ctx_pop = r_valid & r_ready;

    always_comb begin
        if (state == st_sc_rsp) begin
            rsp_valid = 1'b1;
            rsp.dest  = sc_dest;
            rsp.data  = sc_data;
            rsp.sel   = sc_sel;
        end else begin
            rsp_valid = r_valid & ~ctx_empty;
            rsp.dest  = ctx_head.dest;
            rsp.data  = ld_data;
            rsp.sel   = ctx_head.sel;
        end
    end

endmodule

//--- lsu/load_align.sv
`timescale 1ns/1ps

module load_align (
    input  lsu_pkg::load_ctx_t ctx,
    input  logic [31:0]        rdata,
    output logic [31:0]        data
);
    import lsu_pkg::*;

    logic [31:0] lane;
    logic [4:0]  lwl_sh;
    logic [4:0]  lwr_sh;

    always_comb begin
        lane   = rdata >> {ctx.offset, 3'b000};     // addressed byte at bit 0
        lwl_sh = {~ctx.offset, 3'b000};             // 8*(3-offset)
        lwr_sh = {ctx.offset, 3'b000};
        case (ctx.op)
            mem_lb: begin
                data = {{24{lane[7]}}, lane[7:0]};
            end
            mem_lbu: begin
                data = {24'b0, lane[7:0]};
            end
            mem_lh: begin
                data = {{16{lane[15]}}, lane[15:0]};
            end
            mem_lhu: begin
                data = {16'b0, lane[15:0]};
            end
            mem_lwl: begin
                // memory bytes 0..offset fill the top, rt keeps the rest
                data = (rdata << lwl_sh) | (ctx.rt_value & ~(32'hffff_ffff << lwl_sh));
            end
            mem_lwr: begin
                data = (rdata >> lwr_sh) | (ctx.rt_value & ~(32'hffff_ffff >> lwr_sh));
            end
            default: begin
                data = rdata;                       // lw, ll
            end
        endcase
    end

endmodule

//--- lsu/store_format.sv
`timescale 1ns/1ps

module store_format (
    input  lsu_pkg::mem_op_t op,
    input  logic [1:0]       offset,
    input  logic [31:0]      wdata,
    output logic [3:0]       strb,
    output logic [31:0]      data
);
    import lsu_pkg::*;

    always_comb begin
        strb = 4'b0000;
        data = wdata;
        case (op)
            mem_sb: begin
                strb = 4'b0001 << offset;
                data = {4{wdata[7:0]}};
            end
            mem_sh: begin
                strb = offset[1] ? 4'b1100 : 4'b0011;
                data = {2{wdata[15:0]}};
            end
            mem_sw, mem_sc: begin
                strb = 4'b1111;
            end
            mem_swl: begin
                // top bytes of rt go to the low lanes
                strb = 4'b1111 >> (2'd3 - offset);
                data = wdata >> {2'd3 - offset, 3'b000};
            end
            mem_swr: begin
                strb = 4'b1111 << offset;       // low bytes up to lane 3
                data = wdata << {offset, 3'b000};
            end
            default: begin
                strb = 4'b0000;
            end
        endcase
    end

endmodule

//--- lsu_top.f
common/lsu_pkg.sv
src/sync_fifo.sv
lsu/store_format.sv
lsu/load_align.sv
lsu/access_ctrl.sv
lsu/axi_lite_master.sv
src/lsu_top.sv
test/lsu_assertions.sv
test/lsu_checker.sv
test/tb_lsu_top.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the lsu_top testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_lsu_top \
    -f lsu_top.f -o sim_lsu_top > build.log 2>&1 \
    && ./obj_dir/sim_lsu_top > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "Test failures found" sim.log && exit 1
grep -q "All tests passed!" sim.log || exit 1
exit 0

//--- src/lsu_top.sv
`timescale 1ns/1ps

module lsu_top #(
    parameter int REQ_DEPTH = 4,
    parameter int RD_DEPTH  = 4
) (
    input  logic                clk,
    input  logic                arst_n,
    input  lsu_pkg::slot_req_t  slot0,
    input  lsu_pkg::slot_req_t  slot1,
    input  logic                mem_sel,
    input  logic                req_valid,
    output logic                req_ready,
    output lsu_pkg::lsu_rsp_t   rsp,
    output logic                rsp_valid,
    input  logic                rsp_ready,
    output lsu_pkg::lsu_exc_t   exc,
    output logic                exc_valid,
    output lsu_pkg::axi_aw_t    aw,
    output logic                aw_valid,
    input  logic                aw_ready,
    output lsu_pkg::axi_w_t     w,
    output logic                w_valid,
    input  logic                w_ready,
    output lsu_pkg::axi_ar_t    ar,
    output logic                ar_valid,
    input  logic                ar_ready,
    input  logic                b_valid,
    input  lsu_pkg::axi_b_t     b,
    output logic                b_ready,
    input  logic                r_valid,
    input  lsu_pkg::axi_r_t     r,
    output logic                r_ready
);
    import lsu_pkg::*;

    logic     push;
    logic     pop;
    logic     fifo_full;
    logic     fifo_empty;
    lsu_req_t push_item;
    lsu_req_t head;

    access_ctrl u_access_ctrl (
        .clk       (clk),
        .arst_n    (arst_n),
        .slot0     (slot0),
        .slot1     (slot1),
        .mem_sel   (mem_sel),
        .req_valid (req_valid),
        .fifo_full (fifo_full),
        .req_ready (req_ready),
        .push      (push),
        .push_item (push_item),
        .exc       (exc),
        .exc_valid (exc_valid)
    );

    sync_fifo #(
        .item_t (lsu_req_t),
        .DEPTH  (REQ_DEPTH)
    ) u_req_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (push),
        .push_item (push_item),
        .pop       (pop),
        .head      (head),
        .empty     (fifo_empty),
        .full      (fifo_full)
    );

    axi_lite_master #(
        .RD_DEPTH (RD_DEPTH)
    ) u_axi_master (
        .clk       (clk),
        .arst_n    (arst_n),
        .head      (head),
        .empty     (fifo_empty),
        .rsp_ready (rsp_ready),
        .pop       (pop),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .aw        (aw),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .w         (w),
        .w_valid   (w_valid),
        .w_ready   (w_ready),
        .ar        (ar),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .b_valid   (b_valid),
        .b         (b),
        .b_ready   (b_ready),
        .r_valid   (r_valid),
        .r         (r),
        .r_ready   (r_ready)
    );

endmodule

//--- src/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter type item_t = logic [31:0],
    parameter int  DEPTH  = 4
) (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  push,
    input  item_t push_item,
    input  logic  pop,
    output item_t head,
    output logic  empty,
    output logic  full
);
    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    item_t         mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_push;
    logic          do_pop;

    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;
    assign empty   = (count == '0);
    assign full    = (count == CW'(DEPTH));
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + CW'(do_push) - CW'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_item;
    end

endmodule

//--- test/lsu_assertions.sv
`timescale 1ns/1ps

module lsu_assertions (
    input logic              clk,
    input logic              arst_n,
    input lsu_pkg::axi_aw_t  aw,
    input logic              aw_valid,
    input logic              aw_ready,
    input lsu_pkg::axi_w_t   w,
    input logic              w_valid,
    input logic              w_ready,
    input lsu_pkg::axi_ar_t  ar,
    input logic              ar_valid,
    input logic              ar_ready,
    input lsu_pkg::lsu_rsp_t rsp,
    input logic              rsp_valid,
    input logic              rsp_ready,
    input logic              exc_valid,
    input logic              push
);

    a_aw_hold: assert property (@(posedge clk) disable iff (!arst_n)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw))
        else $error("aw dropped or changed before aw_ready");

    a_w_hold: assert property (@(posedge clk) disable iff (!arst_n)
        w_valid && !w_ready |=> w_valid && $stable(w))
        else $error("w dropped or changed before w_ready");

    a_ar_hold: assert property (@(posedge clk) disable iff (!arst_n)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar))
        else $error("ar dropped or changed before ar_ready");

    // response held while stalled
    a_rsp_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else $error("rsp changed under stall");

    a_exc_push: assert property (@(posedge clk) disable iff (!arst_n)
        !(exc_valid && push))
        else $error("exception and push in the same cycle");

endmodule

bind lsu_top lsu_assertions u_lsu_assertions (.*);

//--- test/lsu_checker.sv
`timescale 1ns/1ps

module lsu_checker (
    input  logic               clk,
    input  logic               arst_n,
    input  lsu_pkg::slot_req_t slot0,
    input  lsu_pkg::slot_req_t slot1,
    input  logic               mem_sel, req_valid, req_ready, rsp_valid, rsp_ready, exc_valid,
    input  lsu_pkg::lsu_rsp_t  rsp,
    input  lsu_pkg::lsu_exc_t  exc,
    input  lsu_pkg::axi_aw_t   aw,
    input  lsu_pkg::axi_w_t    w,
    input  lsu_pkg::axi_ar_t   ar,
    input  logic               aw_valid, aw_ready, w_valid, w_ready, ar_valid, ar_ready,
    input  logic               b_ready, r_ready,
    input  logic               report,
    output int                 errors,
    output logic               idle
);
    import lsu_pkg::*;

    logic [31:0] shadow [64];
    logic        link;
    logic        exc_due;
    lsu_exc_t    exp_exc;
    lsu_rsp_t    exp_rsp [$];
    logic [31:0] exp_ar [$];
    logic [31:0] exp_aw [$];
    logic [35:0] exp_w [$];     // {strb, data}
    int          checks;

    // expected strobes, write data and load result for one access
    function automatic void model(input logic [5:0] opc, input logic [1:0] off,
                                  input logic [31:0] rt, input logic [31:0] word,
                                  output logic [3:0] strb, output logic [31:0] wdat,
                                  output logic [31:0] ld, output logic bad);
        logic [7:0] m [4];
        logic [7:0] o [4];
        int         k;
        k = off;
        for (int i = 0; i < 4; i++) begin
            m[i] = word[8*i +: 8];
            o[i] = rt[8*i +: 8];
        end
        strb = 4'b0000;
        wdat = 32'h0;
        ld   = word;
        bad  = 1'b0;
        case (opc)
            op_lb:  ld = {{24{m[k][7]}}, m[k]};
            op_lbu: ld = {24'h0, m[k]};
            op_lh, op_lhu: begin
                bad = off[0];
                ld  = {(opc == op_lh) ? {16{m[k|1][7]}} : 16'h0, m[k|1], m[k]};
            end
            op_lw, op_ll: bad = (k != 0);
            op_lwl: begin
                for (int j = 0; j <= k; j++)
                    o[3-k+j] = m[j];
                ld = {o[3], o[2], o[1], o[0]};
            end
            op_lwr: begin
                for (int j = 0; j <= 3 - k; j++)
                    o[j] = m[k+j];
                ld = {o[3], o[2], o[1], o[0]};
            end
            op_sb: begin
                strb[k] = 1'b1;
                wdat[8*k +: 8] = rt[7:0];
            end
            op_sh: begin
                bad = off[0];
                strb[k|1] = 1'b1;
                strb[k] = 1'b1;
                wdat[8*k +: 16] = rt[15:0];
            end
            op_sw, op_sc: begin
                bad  = (k != 0);
                strb = 4'b1111;
                wdat = rt;
            end
            op_swl: for (int i = 0; i <= k; i++) begin
                strb[i] = 1'b1;
                wdat[8*i +: 8] = rt[8*(i+3-k) +: 8];   // top of rt into low lanes
            end
            op_swr: for (int i = k; i < 4; i++) begin
                strb[i] = 1'b1;
                wdat[8*i +: 8] = rt[8*(i-k) +: 8];
            end
            default: ;
        endcase
    endfunction

    task automatic compare(input string name, input logic [63:0] e, input logic [63:0] a);
        checks++;
        if (e !== a) begin
            errors++;
            $display("Fail %s expected %h actual %h", name, e, a);
        end
    endtask

    task automatic problem(input string what);
        errors++;
        $display("%s", what);
    endtask

    initial begin
        errors = 0;
        checks = 0;
        link = 1'b0;
        exc_due = 1'b0;
        for (int i = 0; i < 64; i++)
            shadow[i] = 32'(i) * 32'h9e37_79b1 + 32'h0bad_c0de;
    end

    always @(posedge clk) begin
        slot_req_t   s;
        logic [5:0]  opc;
        logic [5:0]  idx;
        logic [3:0]  strb;
        logic [31:0] wdat;
        logic [31:0] ld;
        logic [31:0] msk;
        logic        bad;
        logic        is_st;
        lsu_rsp_t    e;
        if (!arst_n) begin
            if (req_ready || rsp_valid || exc_valid || aw_valid || w_valid || ar_valid
                || b_ready || r_ready)
                problem("control output high during reset");
            link = 1'b0;
            exc_due = 1'b0;
        end else begin
            if (exc_due && !exc_valid)
                problem("missing exception after misaligned access");
            else if (exc_due)
                compare("exc", 64'(exp_exc), 64'(exc));
            else if (exc_valid)
                problem("unexpected exception");
            exc_due = 1'b0;
            if (aw_valid && aw_ready) begin
                if (exp_aw.size() == 0)
                    problem("unexpected AW transfer");
                else
                    compare("aw", 64'({exp_aw.pop_front(), 3'b000}), 64'(aw));
            end
            if (w_valid && w_ready) begin
                if (exp_w.size() == 0) begin
                    problem("unexpected W transfer");
                end else begin
                    {strb, wdat} = exp_w.pop_front();
                    msk = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
                    compare("w.strb", 64'(strb), 64'(w.strb));
                    compare("w.data", 64'(wdat & msk), 64'(w.data & msk));
                end
            end
            if (ar_valid && ar_ready) begin
                if (exp_ar.size() == 0)
                    problem("unexpected AR transfer");
                else
                    compare("ar", 64'({exp_ar.pop_front(), 3'b000}), 64'(ar));
            end
            if (rsp_valid && rsp_ready) begin
                if (exp_rsp.size() == 0)
                    problem("response without a matching request");
                else
                    compare("rsp", 64'(exp_rsp.pop_front()), 64'(rsp));
            end
            if (req_valid && req_ready) begin
                s = mem_sel ? slot0 : slot1;
                opc = s.instr[31:26];
                idx = s.addr[7:2];
                is_st = opc inside {op_sb, op_sh, op_swl, op_sw, op_swr, op_sc};
                model(opc, s.addr[1:0], s.wdata, shadow[idx], strb, wdat, ld, bad);
                if (bad) begin
                    exc_due = 1'b1;
                    exp_exc = '{sel: mem_sel, is_store: is_st, badvaddr: s.addr};
                end else if (is_st && (opc != op_sc || link)) begin
                    exp_aw.push_back({s.addr[31:2], 2'b00});
                    exp_w.push_back({strb, wdat});
                    for (int i = 0; i < 4; i++)
                        if (strb[i])
                            shadow[idx][8*i +: 8] = wdat[8*i +: 8];
                end else if (!is_st) begin
                    exp_ar.push_back({s.addr[31:2], 2'b00});
                end
                e = '{dest: s.dest, data: ld, sel: mem_sel};
                if (opc == op_sc)
                    e.data = {31'h0, link};
                if (!bad && (!is_st || opc == op_sc))
                    exp_rsp.push_back(e);
                if (opc == op_sc)
                    link = 1'b0;            // any sc ends the reservation
                else if (opc == op_ll && !bad)
                    link = 1'b1;
            end
        end
        idle <= !exc_due && exp_rsp.size() == 0 && exp_ar.size() == 0
                && exp_aw.size() == 0 && exp_w.size() == 0;
    end

    always @(posedge report)
        $display("checker: %0d checks, %0d errors", checks, errors);

endmodule

//--- test/tb_lsu_top.sv
`timescale 1ns/1ps

module tb_lsu_top;
    import lsu_pkg::*;

    localparam int N_OPS = 400;

    logic      clk;
    logic      arst_n;
    slot_req_t slot0;
    slot_req_t slot1;
    logic      mem_sel, req_valid, req_ready, rsp_valid, rsp_ready, exc_valid;
    lsu_rsp_t  rsp;
    lsu_exc_t  exc;
    axi_aw_t   aw;
    axi_w_t    w;
    axi_ar_t   ar;
    axi_b_t    b;
    axi_r_t    r;
    logic      aw_valid, aw_ready, w_valid, w_ready, ar_valid, ar_ready;
    logic      b_valid, b_ready, r_valid, r_ready;
    logic      report;
    logic      idle;
    int        errors;

    logic [31:0] mem [64];
    logic [31:0] rd_q [$];
    logic [31:0] rng_m;
    logic        got_aw;
    logic        got_w;
    logic [5:0]  wr_idx;
    axi_w_t      wr_beat;

    lsu_top i_lsu_top (.*);
    lsu_checker i_checker (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [5:0] pick_opcode(input logic [3:0] k);
        case (k)
            4'd0:    return op_lb;
            4'd1:    return op_lh;
            4'd2:    return op_lwl;
            4'd3:    return op_lw;
            4'd4:    return op_lbu;
            4'd5:    return op_lhu;
            4'd6:    return op_lwr;
            4'd7:    return op_sb;
            4'd8:    return op_sh;
            4'd9:    return op_swl;
            4'd10:   return op_sw;
            4'd11:   return op_swr;
            4'd12:   return op_ll;
            default: return op_sc;
        endcase
    endfunction

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        {slot0, slot1, mem_sel, req_valid, rsp_ready} = '0;
        {aw_ready, w_ready, ar_ready, b_valid, b, r_valid, r} = '0;
        {got_aw, got_w, report} = '0;
        arst_n = 1'b0;
        rng_m = 32'h24c8 ^ 32'h5555_0000;   // separate stream for the slave
        for (int i = 0; i < 64; i++)
            mem[i] = 32'(i) * 32'h9e37_79b1 + 32'h0bad_c0de;
    end

    // AXI4-Lite slave with random ready and response delays
    always @(posedge clk) begin
        if (arst_n) begin
            rng_m = xorshift32(rng_m);
            aw_ready  <= rng_m[0];
            w_ready   <= rng_m[1];
            ar_ready  <= rng_m[2];
            rsp_ready <= rng_m[5] | rng_m[6];
            if (aw_valid && aw_ready) begin
                got_aw <= 1'b1;
                wr_idx <= aw.addr[7:2];
            end
            if (w_valid && w_ready) begin
                got_w   <= 1'b1;
                wr_beat <= w;
            end
            if (b_valid && b_ready)
                b_valid <= 1'b0;
            if (got_aw && got_w && !b_valid && rng_m[3]) begin
                for (int i = 0; i < 4; i++)
                    if (wr_beat.strb[i])
                        mem[wr_idx][8*i +: 8] <= wr_beat.data[8*i +: 8];
                b_valid <= 1'b1;
                got_aw  <= 1'b0;
                got_w   <= 1'b0;
            end
            if (ar_valid && ar_ready)
                rd_q.push_back(mem[ar.addr[7:2]]);
            if (r_valid && r_ready)
                r_valid <= 1'b0;
            if ((!r_valid || r_ready) && rd_q.size() > 0 && rng_m[4]) begin
                r_valid <= 1'b1;
                r.data  <= rd_q.pop_front();
            end
        end
    end

    initial begin
        logic [31:0] rng_s;
        logic [5:0]  opc;
        logic [5:0]  idx;
        logic [5:0]  prev_idx;
        logic [1:0]  off;
        logic        prev_ll;
        logic        pick;
        slot_req_t   s;
        slot_req_t   junk;
        rng_s = 32'h24c8;
        prev_ll = 1'b0;
        prev_idx = '0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        for (int n = 0; n < N_OPS; n++) begin
            rng_s = xorshift32(rng_s);
            opc = pick_opcode(4'(rng_s[3:0] % 14));
            off = rng_s[4] ? 2'b00 : rng_s[6:5];
            idx = rng_s[13:8];
            if (prev_ll && rng_s[7]) begin
                opc = op_sc;                // reservation pair
                off = 2'b00;
                idx = prev_idx;
            end
            s.instr = {opc, rng_s[31:6]};
            s.addr  = {24'h0, idx, off};
            s.dest  = rng_s[18:14];
            s.valid = 1'b1;
            pick = rng_s[19];
            mem_sel <= pick;
            rng_s = xorshift32(rng_s);
            s.wdata = rng_s;
            junk = '{instr: 32'h0, addr: rng_s, wdata: ~rng_s, dest: 5'd0, valid: rng_s[0]};
            slot0 <= pick ? s : junk;
            slot1 <= pick ? junk : s;
            req_valid <= 1'b1;
            do @(posedge clk); while (!req_ready);
            req_valid <= 1'b0;
            prev_ll = (opc == op_ll) && (off == 2'b00);
            prev_idx = idx;
            repeat (rng_s[21:20]) @(posedge clk);
        end
        do @(posedge clk); while (!idle);
        report <= 1'b1;
        @(negedge clk);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    initial begin
        repeat (N_OPS * 60 + 200) @(posedge clk);
        $display("Timeout: the run did not finish in time, %0d errors so far", errors);
        $display("Test failures found");
        $finish;
    end

endmodule
